/* hw/crate_bridge_pkg.sv */
`default_nettype none

package crate_bridge_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    // Link endpoints behind the bridge
    localparam int NUM_LINKS = 4;
    // Bits needed to name one link
    localparam int LINK_SEL_W = $clog2(NUM_LINKS);

    // Crate address, link select sits in the top bits
    localparam int CRATE_ADDR_W = 27;
    // Register address inside one link
    localparam int LINK_ADDR_W = 25;

    // Data and command word width
    localparam int DATA_W = 32;

    //////////////////////////////////////////////////
    // Command word layout
    //////////////////////////////////////////////////

    // Header: write flag on top, zero pad, register address below
    localparam int WRITE_FLAG_BIT = 31;
    // Zero bits between flag and address
    localparam int HDR_PAD_W = WRITE_FLAG_BIT - LINK_ADDR_W;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [LINK_SEL_W-1:0]   link_id_t;
    typedef logic [NUM_LINKS-1:0]    link_mask_t;
    typedef logic [CRATE_ADDR_W-1:0] crate_addr_t;
    typedef logic [LINK_ADDR_W-1:0]  reg_addr_t;
    typedef logic [DATA_W-1:0]       data_t;

    // Link number from crate address bits 26:25
    function automatic link_id_t addr_link(input crate_addr_t addr);
        return addr[CRATE_ADDR_W-1 -: LINK_SEL_W];
    endfunction

    // Register address from crate address bits 24:0
    function automatic reg_addr_t addr_reg(input crate_addr_t addr);
        return addr[LINK_ADDR_W-1:0];
    endfunction

    // First word of a command
    function automatic data_t make_header(input logic write, input reg_addr_t addr);
        return {write, {HDR_PAD_W{1'b0}}, addr};
    endfunction

    // Second word of a command, reads carry zero
    function automatic data_t make_payload(input logic write, input data_t wdata);
        return write ? wdata : '0;
    endfunction

endpackage

`default_nettype wire

/* hw/link_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Decoded request, decode stage to issue stage
// Item holds still while valid is high
// Consumed in the cycle take is high
interface link_cmd_if;
    import crate_bridge_pkg::*;

    // Item present
    logic      valid;
    // Target link
    link_id_t  link;
    // Write when high, read when low
    logic      write;
    // Link was up at acceptance
    logic      link_ok;
    // Register address within the link
    reg_addr_t addr;
    // Write data, don't care for reads
    data_t     data;
    // Issue stage consumes the item
    logic      take;

    modport decode_mp (
        output valid,
        output link,
        output write,
        output link_ok,
        output addr,
        output data,
        input  take
    );

    modport issue_mp (
        input  valid,
        input  link,
        input  write,
        input  link_ok,
        input  addr,
        input  data,
        output take
    );

endinterface

`default_nettype wire

/* hw/bridge_decode.sv */
`timescale 1ns/1ps
`default_nettype none

// First stage: request intake and link decode
module bridge_decode (
    input  wire logic                        ps_clk,
    input  wire logic                        arst_n_i,
    // Request side
    input  wire logic                        req_valid_i,
    input  wire logic                        req_write_i,
    input  wire crate_bridge_pkg::crate_addr_t req_addr_i,
    input  wire crate_bridge_pkg::data_t     req_wdata_i,
    output logic                             req_ready_o,
    // Per-link up status
    input  wire crate_bridge_pkg::link_mask_t link_up_i,
    // Response produced downstream
    input  wire logic                        done_i,
    // Decoded item to issue stage
    link_cmd_if.decode_mp                    cmd
);
    import crate_bridge_pkg::*;

    //////////////////////////////////////////////////
    // Acceptance
    //////////////////////////////////////////////////

    // One transaction in flight, from accept to done
    logic     pending;
    // Request taken this edge
    logic     accept;
    // Link picked by address top bits
    link_id_t sel_link;

    assign req_ready_o = ~pending;
    assign accept      = req_valid_i & ~pending;
    assign sel_link    = addr_link(req_addr_i);

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending   <= 1'b0;
            cmd.valid <= 1'b0;
        end else begin
            // Set on accept, dropped once response goes out
            if (accept) begin
                pending <= 1'b1;
            end else if (done_i) begin
                pending <= 1'b0;
            end
            // Item shown from next cycle until issue takes it
            if (accept) begin
                cmd.valid <= 1'b1;
            end else if (cmd.take) begin
                cmd.valid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Item fields
    //////////////////////////////////////////////////

    // Captured on the accepting edge, stable until take
    always_ff @(posedge ps_clk) begin
        if (accept) begin
            cmd.link    <= sel_link;
            cmd.write   <= req_write_i;
            cmd.addr    <= addr_reg(req_addr_i);
            cmd.data    <= req_wdata_i;
            // Link status sampled once, at acceptance
            cmd.link_ok <= link_up_i[sel_link];
        end
    end

endmodule

`default_nettype wire

/* hw/bridge_issue.sv */
`timescale 1ns/1ps
`default_nettype none

// Second stage: credit tracking and command framing
module bridge_issue #(
    parameter int CREDIT_MAX = 4
) (
    input  wire logic                         ps_clk,
    input  wire logic                         arst_n_i,
    // One credit pulse per link
    input  wire crate_bridge_pkg::link_mask_t credit_i,
    // Decoded item from decode stage
    link_cmd_if.issue_mp                      cmd,
    // Command side
    output crate_bridge_pkg::link_mask_t      cmd_valid_o,
    output crate_bridge_pkg::data_t           cmd_data_o,
    output logic                              cmd_last_o,
    // To tracker
    output logic                              sent_o,
    output logic                              rejected_o,
    output crate_bridge_pkg::link_id_t        sent_link_o
);
    import crate_bridge_pkg::*;

    localparam int CNT_W = $clog2(CREDIT_MAX + 1);

    // Which word of the pair is next
    typedef enum logic {
        PH_HDR,
        PH_DAT
    } phase_t;

    //////////////////////////////////////////////////
    // Credit counters
    //////////////////////////////////////////////////

    logic [CNT_W-1:0] credit_cnt [NUM_LINKS];
    // Link has at least one credit
    link_mask_t       has_credit;

    for (genvar l = 0; l < NUM_LINKS; l++) begin : g_credit
        assign has_credit[l] = (credit_cnt[l] != '0);

        always_ff @(posedge ps_clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                credit_cnt[l] <= CNT_W'(CREDIT_MAX);
            end else if (credit_i[l] && !cmd_valid_o[l]) begin
                // Returned credit, held at the ceiling
                if (credit_cnt[l] != CNT_W'(CREDIT_MAX)) begin
                    credit_cnt[l] <= credit_cnt[l] + 1'b1;
                end
            end else if (cmd_valid_o[l] && !credit_i[l]) begin
                // Word out, never below zero since send needs credit
                credit_cnt[l] <= credit_cnt[l] - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Serializer
    //////////////////////////////////////////////////

    logic     busy;
    phase_t   phase;
    link_id_t cur_link;
    data_t    hdr_q;
    data_t    dat_q;
    // Current word leaves this cycle
    logic     can_send;

    // Only take a new item once the pair is out
    assign cmd.take = cmd.valid & ~busy;
    assign can_send = busy & has_credit[cur_link];

    assign cmd_valid_o = can_send ? link_mask_t'(1) << cur_link : '0;
    assign cmd_data_o  = (phase == PH_HDR) ? hdr_q : dat_q;
    assign cmd_last_o  = can_send & (phase == PH_DAT);
    // Last word leaving closes the command
    assign sent_o      = cmd_last_o;
    assign sent_link_o = cur_link;

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy       <= 1'b0;
            phase      <= PH_HDR;
            rejected_o <= 1'b0;
        end else begin
            rejected_o <= 1'b0;
            if (cmd.take) begin
                // Dead link, pass it on without sending
                if (cmd.link_ok) begin
                    busy  <= 1'b1;
                    phase <= PH_HDR;
                end else begin
                    rejected_o <= 1'b1;
                end
            end else if (can_send) begin
                if (phase == PH_HDR) begin
                    phase <= PH_DAT;
                end else begin
                    phase <= PH_HDR;
                    busy  <= 1'b0;
                end
            end
        end
    end

    // Words built once, when the item is taken
    always_ff @(posedge ps_clk) begin
        if (cmd.take) begin
            cur_link <= cmd.link;
            hdr_q    <= make_header(cmd.write, cmd.addr);
            dat_q    <= make_payload(cmd.write, cmd.data);
        end
    end

endmodule

`default_nettype wire

/* hw/bridge_track.sv */
`timescale 1ns/1ps
`default_nettype none

// Third stage: reply matching, timeout and status flags
module bridge_track #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  wire logic                         ps_clk,
    input  wire logic                         arst_n_i,
    // From issue stage
    input  wire logic                         sent_i,
    input  wire logic                         rejected_i,
    input  wire crate_bridge_pkg::link_id_t   sent_link_i,
    // Reply side, always accepted
    input  wire logic                         rsp_valid_i,
    input  wire crate_bridge_pkg::link_id_t   rsp_link_i,
    input  wire crate_bridge_pkg::data_t      rsp_data_i,
    // Flag clear request
    input  wire logic                         clear_flags_i,
    // Back to decode stage
    output logic                              done_o,
    // Response side
    output logic                              resp_valid_o,
    output crate_bridge_pkg::data_t           resp_data_o,
    output logic                              resp_err_o,
    output crate_bridge_pkg::link_mask_t      timeout_flags_o,
    output crate_bridge_pkg::link_mask_t      invalid_flags_o
);
    import crate_bridge_pkg::*;

    localparam int TIMER_W = $clog2(TIMEOUT_CYCLES + 1);

    //////////////////////////////////////////////////
    // Outstanding command
    //////////////////////////////////////////////////

    logic               outstanding;
    link_id_t           out_link;
    logic [TIMER_W-1:0] timer;
    // Reply from the link we wait on
    logic               rsp_match;
    // Wait over, no reply
    logic               expired;
    // Per-link flag sets this cycle
    link_mask_t         set_timeout;
    link_mask_t         set_invalid;

    assign rsp_match = outstanding & rsp_valid_i & (rsp_link_i == out_link);
    // Loaded with 1 after last word, so expiry lands TIMEOUT_CYCLES later
    assign expired   = outstanding & ~rsp_match & (timer == TIMER_W'(TIMEOUT_CYCLES - 1));

    assign set_timeout = expired    ? link_mask_t'(1) << out_link    : '0;
    assign set_invalid = rejected_i ? link_mask_t'(1) << sent_link_i : '0;

    // Response pulse frees the decode stage
    assign done_o = resp_valid_o;

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            outstanding  <= 1'b0;
            timer        <= '0;
            resp_valid_o <= 1'b0;
            resp_err_o   <= 1'b0;
        end else begin
            resp_valid_o <= 1'b0;
            if (sent_i) begin
                // Start waiting
                outstanding <= 1'b1;
                timer       <= TIMER_W'(1);
            end else if (rsp_match) begin
                outstanding  <= 1'b0;
                resp_valid_o <= 1'b1;
                resp_err_o   <= 1'b0;
            end else if (expired) begin
                outstanding  <= 1'b0;
                resp_valid_o <= 1'b1;
                resp_err_o   <= 1'b1;
            end else if (rejected_i) begin
                // Dead link, answer at once
                resp_valid_o <= 1'b1;
                resp_err_o   <= 1'b1;
            end else if (outstanding) begin
                timer <= timer + 1'b1;
            end
        end
    end

    // Stray replies land here too but are never presented
    always_ff @(posedge ps_clk) begin
        if (sent_i) begin
            out_link <= sent_link_i;
        end
        // Errors carry zero data
        resp_data_o <= rsp_match ? rsp_data_i : '0;
    end

    //////////////////////////////////////////////////
    // Sticky flags
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            timeout_flags_o <= '0;
            invalid_flags_o <= '0;
        end else if (clear_flags_i) begin
            // Clear wins over a same-cycle set
            timeout_flags_o <= '0;
            invalid_flags_o <= '0;
        end else begin
            timeout_flags_o <= timeout_flags_o | set_timeout;
            invalid_flags_o <= invalid_flags_o | set_invalid;
        end
    end

endmodule

`default_nettype wire

/* hw/crate_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

// Crate register bridge, request in, two-word command out per link
module crate_bridge #(
    parameter int CREDIT_MAX     = 4,
    parameter int TIMEOUT_CYCLES = 64
) (
    input  wire logic                          ps_clk,
    input  wire logic                          arst_n_i,
    // Requests from processor side
    input  wire logic                          req_valid_i,
    input  wire logic                          req_write_i,
    input  wire crate_bridge_pkg::crate_addr_t req_addr_i,
    input  wire crate_bridge_pkg::data_t       req_wdata_i,
    output logic                               req_ready_o,
    // Link status and credits
    input  wire crate_bridge_pkg::link_mask_t  link_up_i,
    input  wire crate_bridge_pkg::link_mask_t  credit_i,
    // Commands to endpoints
    output crate_bridge_pkg::link_mask_t       cmd_valid_o,
    output crate_bridge_pkg::data_t            cmd_data_o,
    output logic                               cmd_last_o,
    // Replies from endpoints
    input  wire logic                          rsp_valid_i,
    input  wire crate_bridge_pkg::link_id_t    rsp_link_i,
    input  wire crate_bridge_pkg::data_t       rsp_data_i,
    // Responses and status
    output logic                               resp_valid_o,
    output crate_bridge_pkg::data_t            resp_data_o,
    output logic                               resp_err_o,
    output crate_bridge_pkg::link_mask_t       timeout_flags_o,
    output crate_bridge_pkg::link_mask_t       invalid_flags_o,
    input  wire logic                          clear_flags_i
);
    import crate_bridge_pkg::*;

    //////////////////////////////////////////////////
    // Stage links
    //////////////////////////////////////////////////

    // Decode to issue
    link_cmd_if u_cmd_if ();

    // Issue to track
    logic     sent;
    logic     rejected;
    link_id_t sent_link;
    // Track to decode
    logic     done;

    bridge_decode u_decode (
        .ps_clk      (ps_clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_ready_o (req_ready_o),
        .link_up_i   (link_up_i),
        .done_i      (done),
        .cmd         (u_cmd_if.decode_mp)
    );

    bridge_issue #(
        .CREDIT_MAX (CREDIT_MAX)
    ) u_issue (
        .ps_clk      (ps_clk),
        .arst_n_i    (arst_n_i),
        .credit_i    (credit_i),
        .cmd         (u_cmd_if.issue_mp),
        .cmd_valid_o (cmd_valid_o),
        .cmd_data_o  (cmd_data_o),
        .cmd_last_o  (cmd_last_o),
        .sent_o      (sent),
        .rejected_o  (rejected),
        .sent_link_o (sent_link)
    );

    bridge_track #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_track (
        .ps_clk          (ps_clk),
        .arst_n_i        (arst_n_i),
        .sent_i          (sent),
        .rejected_i      (rejected),
        .sent_link_i     (sent_link),
        .rsp_valid_i     (rsp_valid_i),
        .rsp_link_i      (rsp_link_i),
        .rsp_data_i      (rsp_data_i),
        .clear_flags_i   (clear_flags_i),
        .done_o          (done),
        .resp_valid_o    (resp_valid_o),
        .resp_data_o     (resp_data_o),
        .resp_err_o      (resp_err_o),
        .timeout_flags_o (timeout_flags_o),
        .invalid_flags_o (invalid_flags_o)
    );

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and power-on reset
module tb_clock #(
    parameter real PERIOD_NS    = 100.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/crate_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench for the crate register bridge
module crate_bridge_tb;
    import crate_bridge_pkg::*;

    localparam real         CLK_PERIOD_NS  = 100.0;
    localparam int unsigned SEED           = 32'hef33_f1ea;
    // DUT defaults
    localparam int          CREDIT_MAX     = 4;
    localparam int          TIMEOUT_CYCLES = 64;
    // Run budget per transaction, worst case is a timeout
    localparam int          NUM_TXN        = 40;
    localparam int          CYCLE_LIMIT    = NUM_TXN * (TIMEOUT_CYCLES + 20);
    // Endpoint reply is the header XOR this
    localparam data_t       REPLY_KEY      = 32'h5a5a_c3c3;

    logic        ps_clk;
    logic        arst_n;
    // DUT inputs
    logic        req_valid;
    logic        req_write;
    crate_addr_t req_addr;
    data_t       req_wdata;
    link_mask_t  link_up;
    link_mask_t  credit;
    logic        rsp_valid;
    link_id_t    rsp_link;
    data_t       rsp_data;
    logic        clear_flags;
    // DUT outputs
    logic        req_ready;
    link_mask_t  cmd_valid;
    data_t       cmd_data;
    logic        cmd_last;
    logic        resp_valid;
    data_t       resp_data;
    logic        resp_err;
    link_mask_t  timeout_flags;
    link_mask_t  invalid_flags;

    // Endpoint controls, per link
    link_mask_t  silent;
    link_mask_t  hold_credit;

    // Bookkeeping
    int          cycle = 0;
    int          errors = 0;
    int          n_txn = 0;
    logic        in_flight;
    int          acc_cycle;
    int          last_cycle;
    int          words_seen;
    link_id_t    exp_link;
    logic        exp_ok;
    data_t       exp_hdr;
    data_t       exp_data;
    // Words held by each endpoint, credit not yet returned
    int          owed [NUM_LINKS];
    data_t       rx_hdr;
    logic        reply_armed;
    link_id_t    reply_link;
    data_t       reply_data;
    int          reply_due;

    tb_clock #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (2)
    ) u_clock (
        .clk_o    (ps_clk),
        .arst_n_o (arst_n)
    );

    crate_bridge u_crate_bridge (
        .ps_clk          (ps_clk),
        .arst_n_i        (arst_n),
        .req_valid_i     (req_valid),
        .req_write_i     (req_write),
        .req_addr_i      (req_addr),
        .req_wdata_i     (req_wdata),
        .req_ready_o     (req_ready),
        .link_up_i       (link_up),
        .credit_i        (credit),
        .cmd_valid_o     (cmd_valid),
        .cmd_data_o      (cmd_data),
        .cmd_last_o      (cmd_last),
        .rsp_valid_i     (rsp_valid),
        .rsp_link_i      (rsp_link),
        .rsp_data_i      (rsp_data),
        .resp_valid_o    (resp_valid),
        .resp_data_o     (resp_data),
        .resp_err_o      (resp_err),
        .timeout_flags_o (timeout_flags),
        .invalid_flags_o (invalid_flags),
        .clear_flags_i   (clear_flags)
    );

    task automatic note_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    // Write flag on bit 31, zero pad, register address in 24:0
    function automatic data_t header_for(input logic write, input crate_addr_t addr);
        return {write, 6'b0, addr[24:0]};
    endfunction

    function automatic link_id_t mask_index(input link_mask_t mask);
        link_id_t idx;
        idx = '0;
        for (int l = 0; l < NUM_LINKS; l++) begin
            if (mask[l]) begin
                idx = link_id_t'(l);
            end
        end
        return idx;
    endfunction

    //////////////////////////////////////////////////
    // Cycle count and run limit
    //////////////////////////////////////////////////

    always @(posedge ps_clk) begin
        cycle <= cycle + 1;
        if (cycle == CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Expected transaction and endpoint model
    //////////////////////////////////////////////////

    always @(posedge ps_clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight   <= 1'b0;
            words_seen  <= 0;
            reply_armed <= 1'b0;
            for (int l = 0; l < NUM_LINKS; l++) begin
                owed[l] <= 0;
            end
        end else begin
            // Expected command from the accepted request
            if (req_valid && req_ready) begin
                in_flight  <= 1'b1;
                acc_cycle  <= cycle;
                words_seen <= 0;
                exp_link   <= req_addr[26:25];
                exp_ok     <= link_up[req_addr[26:25]];
                exp_hdr    <= header_for(req_write, req_addr);
                exp_data   <= req_write ? req_wdata : '0;
            end
            if (resp_valid) begin
                in_flight <= 1'b0;
            end
            // Words seen by the endpoints
            if (cmd_valid != '0) begin
                words_seen <= words_seen + 1;
                if (!cmd_last) begin
                    rx_hdr <= cmd_data;
                end else begin
                    last_cycle <= cycle;
                    // Silent endpoint never answers
                    if (!silent[mask_index(cmd_valid)]) begin
                        reply_armed <= 1'b1;
                        reply_link  <= mask_index(cmd_valid);
                        reply_data  <= rx_hdr ^ REPLY_KEY;
                        reply_due   <= cycle + int'($urandom_range(8, 1));
                    end
                end
            end
            if (rsp_valid) begin
                reply_armed <= 1'b0;
            end
            for (int l = 0; l < NUM_LINKS; l++) begin
                owed[l] <= owed[l] + int'(cmd_valid[l]) - int'(credit[l]);
            end
        end
    end

    // Endpoint outputs, driven on the falling edge
    initial begin
        rsp_valid = 1'b0;
        rsp_link  = '0;
        rsp_data  = '0;
        credit    = '0;
        forever begin
            @(negedge ps_clk);
            rsp_valid = reply_armed && (cycle >= reply_due);
            rsp_link  = reply_link;
            rsp_data  = reply_data;
            // Credits trickle back at random
            for (int l = 0; l < NUM_LINKS; l++) begin
                credit[l] = (owed[l] > 0) && !hold_credit[l] && ($urandom_range(2, 0) == 0);
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Outputs at their reset values
    a_reset: assert property (@(posedge ps_clk) $rose(arst_n) |->
        (req_ready && cmd_valid == '0 && !cmd_last && !resp_valid
         && timeout_flags == '0 && invalid_flags == '0))
        else note_error("outputs not at reset values after reset");

    // Header first, on the addressed link
    a_header: assert property (@(posedge ps_clk) disable iff (!arst_n)
        (cmd_valid != '0 && words_seen == 0) |->
        (cmd_valid == (link_mask_t'(1) << exp_link) && cmd_data == exp_hdr
         && !cmd_last && cycle - acc_cycle >= 2))
        else note_error($sformatf("header %h on links %b, expected %h on link %0d",
                                  cmd_data, cmd_valid, exp_hdr, exp_link));

    // Data word second, zero for reads, marked last
    a_payload: assert property (@(posedge ps_clk) disable iff (!arst_n)
        (cmd_valid != '0 && words_seen == 1) |->
        (cmd_valid == (link_mask_t'(1) << exp_link) && cmd_data == exp_data && cmd_last))
        else note_error($sformatf("data word %h last %b, expected %h",
                                  cmd_data, cmd_last, exp_data));

    // Only two words, and none for a dead link
    a_word_count: assert property (@(posedge ps_clk) disable iff (!arst_n)
        (cmd_valid != '0) |-> (in_flight && exp_ok && words_seen < 2))
        else note_error("command word sent outside a valid transaction");

    // One transaction at a time
    a_ready: assert property (@(posedge ps_clk) disable iff (!arst_n)
        req_ready == !in_flight)
        else note_error($sformatf("req_ready %b with in-flight %b", req_ready, in_flight));

    a_resp_owned: assert property (@(posedge ps_clk) disable iff (!arst_n)
        resp_valid |-> in_flight)
        else note_error("response without an accepted request");

    a_resp_invalid: assert property (@(posedge ps_clk) disable iff (!arst_n)
        (resp_valid && !exp_ok) |->
        (resp_err && resp_data == '0 && cycle - acc_cycle == 3 && invalid_flags[exp_link]))
        else note_error($sformatf("invalid access: err %b data %h after %0d cycles",
                                  resp_err, resp_data, cycle - acc_cycle));

    a_resp_reply: assert property (@(posedge ps_clk) disable iff (!arst_n)
        (resp_valid && exp_ok && !silent[exp_link]) |->
        (!resp_err && resp_data == (exp_hdr ^ REPLY_KEY)))
        else note_error($sformatf("response %h err %b, expected %h",
                                  resp_data, resp_err, exp_hdr ^ REPLY_KEY));

    // Timeout no earlier than TIMEOUT_CYCLES after the last word
    a_resp_timeout: assert property (@(posedge ps_clk) disable iff (!arst_n)
        (resp_valid && exp_ok && silent[exp_link]) |->
        (resp_err && resp_data == '0 && cycle - last_cycle >= TIMEOUT_CYCLES
         && timeout_flags[exp_link]))
        else note_error($sformatf("timeout: err %b flags %b after %0d cycles",
                                  resp_err, timeout_flags, cycle - last_cycle));

    a_clear: assert property (@(posedge ps_clk) disable iff (!arst_n)
        clear_flags |=> (timeout_flags == '0 && invalid_flags == '0))
        else note_error("flags not cleared");

    // Never more words in flight than credits allow
    for (genvar l = 0; l < NUM_LINKS; l++) begin : g_credit_check
        a_credit: assert property (@(posedge ps_clk) disable iff (!arst_n)
            cmd_valid[l] |-> (owed[l] < CREDIT_MAX))
            else note_error($sformatf("link %0d sent a word with no credit", l));
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Starts and ends on a falling edge
    task automatic send_request(input logic write, input link_id_t link, input data_t wdata);
        while (!req_ready) @(negedge ps_clk);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = {link, reg_addr_t'($urandom)};
        req_wdata = wdata;
        @(negedge ps_clk);
        req_valid = 1'b0;
        n_txn++;
    endtask

    task automatic wait_response();
        while (!resp_valid) @(negedge ps_clk);
        @(negedge ps_clk);
    endtask

    task automatic run_request(input logic write, input link_id_t link, input data_t wdata);
        send_request(write, link, wdata);
        wait_response();
    endtask

    initial begin
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        link_up     = '1;
        clear_flags = 1'b0;
        silent      = '0;
        hold_credit = '0;
        void'($urandom(SEED));

        wait (arst_n);
        repeat (2) @(negedge ps_clk);

        // Writes, then reads, on every link
        for (int i = 0; i < 8; i++) begin
            run_request(1'b1, link_id_t'(i % NUM_LINKS), $urandom);
        end
        for (int i = 0; i < 4; i++) begin
            run_request(1'b0, link_id_t'(i), $urandom);
        end

        // Link 2 down
        link_up = 4'b1011;
        run_request(1'b0, 2'd2, $urandom);
        run_request(1'b1, 2'd2, $urandom);
        link_up = '1;

        // Link 1 starved, third command stalls until credits return
        while (owed[1] != 0) @(negedge ps_clk);
        hold_credit[1] = 1'b1;
        run_request(1'b1, 2'd1, $urandom);
        run_request(1'b1, 2'd1, $urandom);
        send_request(1'b1, 2'd1, $urandom);
        repeat (20) @(negedge ps_clk);
        hold_credit[1] = 1'b0;
        wait_response();

        // Link 3 never answers
        silent[3] = 1'b1;
        run_request(1'b0, 2'd3, '0);
        silent[3] = 1'b0;
        clear_flags = 1'b1;
        @(negedge ps_clk);
        clear_flags = 1'b0;

        // Random mix, link 0 always up
        for (int i = 0; i < 15; i++) begin
            link_up = link_mask_t'($urandom) | 4'b0001;
            run_request(1'($urandom), link_id_t'($urandom), $urandom);
        end
        link_up = '1;
        clear_flags = 1'b1;
        @(negedge ps_clk);
        clear_flags = 1'b0;
        repeat (4) @(negedge ps_clk);

        $display("Finished %0d transactions with %0d errors", n_txn, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* crate_bridge.f */
hw/crate_bridge_pkg.sv
hw/link_cmd_if.sv
hw/bridge_decode.sv
hw/bridge_issue.sv
hw/bridge_track.sv
hw/crate_bridge.sv
verif/tb_clock.sv
verif/crate_bridge_tb.sv

/* Makefile */
# Verilator build and run for the crate bridge testbench

VERILATOR ?= verilator
TOP       ?= crate_bridge_tb
FILELIST  ?= crate_bridge.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= No errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation prints the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
